/* test/bp_cases.txt */
// sel opcode taken pc_exe pc_target bimm_exe pc_fetch exp_prediction exp_target
// one record per clock, all hex; a report is visible to fetch from the next record on
0 13 0 00000000 00000000 00000000 00000000 0 ffffffff
0 13 0 00000000 00000000 00000000 00000100 0 ffffffff
1 63 1 00000100 00000000 fffffff0 00000100 0 ffffffff
1 63 0 00000200 00000000 00000020 00000100 0 ffffffff
1 63 1 00000100 00000000 fffffff0 00000100 0 ffffffff
1 63 1 00000100 00000000 fffffff0 00000100 0 ffffffff
0 13 0 00000000 00000000 00000000 00000100 1 000000f0
1 63 1 00000400 00000000 00000040 00000100 1 000000f0
1 63 1 00000500 00000000 00000080 00000400 0 ffffffff
1 63 1 00000600 00000000 00000100 00000500 0 ffffffff
0 63 1 00000700 00000000 00000010 00000600 0 ffffffff
1 63 0 00000800 00000000 00000010 00000100 1 000000f0
0 13 0 00000000 00000000 00000000 00000100 1 000000f0
1 63 1 00000700 00000000 00000010 00000700 0 ffffffff
0 13 0 00000000 00000000 00000000 00000100 0 ffffffff
0 13 0 00000000 00000000 00000000 00000700 0 ffffffff
1 63 1 00000400 00000000 00000040 00000400 0 ffffffff
1 63 1 00000400 00000000 00000040 00000400 0 ffffffff
0 13 0 00000000 00000000 00000000 00000400 1 00000440
1 63 0 00000400 00000000 00000040 00000400 1 00000440
0 13 0 00000000 00000000 00000000 00000400 0 ffffffff
1 6f 1 00001000 00002000 00000000 00001000 0 ffffffff
1 6f 1 00001100 00003000 00000000 00001000 1 00002000
1 6f 1 00001000 00002000 00000000 00001100 1 00003000
1 6f 1 00001200 00004000 00000000 00001000 1 00002000
0 13 0 00000000 00000000 00000000 00001100 1 00003000
0 13 0 00000000 00000000 00000000 00001000 0 ffffffff
0 13 0 00000000 00000000 00000000 00001200 1 00004000
1 6f 1 00000500 00005000 00000000 00000500 0 ffffffff
0 13 0 00000000 00000000 00000000 00000500 0 ffffffff
0 13 0 00000000 00000000 00000000 00001100 0 ffffffff

/* verilog.f */
rtl/bp_pkg.sv
rtl/tbl_if.sv
rtl/hist_predictor.sv
rtl/tag_table.sv
rtl/bp_update_ctrl.sv
rtl/bp_fetch_lookup.sv
rtl/branch_predictor.sv
test/tb_branch_predictor.sv

/* test/tb_branch_predictor.sv */
`default_nettype none

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int N_CASES    = 31;  // records in the case file
    localparam int LOOP_LIMIT = 200; // read loop bound, comment lines included

    logic    clk;
    logic    rst;
    logic    sel;
    opcode_t opcode;
    logic    branch_taken;
    word_t   pc_exe;
    word_t   pc_target;
    word_t   bimm_exe;
    word_t   pc_fetch;
    logic    prediction;
    word_t   target;

    int              fd;
    int              errors;
    int              n_rec;
    int              loop_cnt;
    int              n_fields;
    logic [8*200-1:0] line;
    logic [31:0]     f_sel, f_op, f_bt, f_pc_exe, f_pc_target;
    logic [31:0]     f_bimm, f_pc_fetch, f_pred, f_target;

    branch_predictor #(
        .BTB_DEPTH (4),
        .JTB_DEPTH (2)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .sel          (sel),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .pc_exe       (pc_exe),
        .pc_target    (pc_target),
        .bimm_exe     (bimm_exe),
        .pc_fetch     (pc_fetch),
        .prediction   (prediction),
        .target       (target)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_outputs(input logic exp_pred, input word_t exp_target);
        assert (prediction === exp_pred) else begin
            errors++;
            $display("ERROR prediction record %0d expected %h got %h",
                     n_rec, exp_pred, prediction);
        end
        assert (target === exp_target) else begin
            errors++;
            $display("ERROR target record %0d expected %h got %h",
                     n_rec, exp_target, target);
        end
    endtask

    initial begin
        rst          = 1'b1;
        sel          = 1'b0;
        opcode       = op_imm;
        branch_taken = 1'b0;
        pc_exe       = '0;
        pc_target    = '0;
        bimm_exe     = '0;
        pc_fetch     = '0;
        errors       = 0;
        n_rec        = 0;
        loop_cnt     = 0;
        fd = $fopen("test/bp_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the case file test/bp_cases.txt");
        end
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;
        if (fd != 0) begin
            while (!$feof(fd) && loop_cnt < LOOP_LIMIT) begin
                loop_cnt++;
                if ($fgets(line, fd) != 0) begin
                    n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                       f_sel, f_op, f_bt, f_pc_exe, f_pc_target,
                                       f_bimm, f_pc_fetch, f_pred, f_target);
                    if (n_fields == 9) begin
                        sel          = f_sel[0];
                        opcode       = opcode_t'(f_op[6:0]);
                        branch_taken = f_bt[0];
                        pc_exe       = f_pc_exe;
                        pc_target    = f_pc_target;
                        bimm_exe     = f_bimm;
                        pc_fetch     = f_pc_fetch;
                        #80; // just before the next rising edge
                        compare_outputs(f_pred[0], f_target);
                        n_rec++;
                        @(posedge clk);
                        #10;
                    end else if (n_fields > 0) begin
                        errors++;
                        $display("case file line after record %0d has %0d fields, 9 needed",
                                 n_rec, n_fields);
                    end
                end
            end
            if (!$feof(fd)) begin
                errors++;
                $display("case file reading stopped at the loop limit of %0d", LOOP_LIMIT);
            end
            $fclose(fd);
            if (n_rec < N_CASES) begin
                errors++;
                $display("case file ended after %0d records, %0d expected", n_rec, N_CASES);
            end
        end
        $display("records %0d errors %0d", n_rec, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/branch_predictor.sv */
`default_nettype none

module branch_predictor #(
    parameter int BTB_DEPTH = 32,
    parameter int JTB_DEPTH = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            sel,          // first execute cycle of the instr
    input  bp_pkg::opcode_t opcode,
    input  logic            branch_taken,
    input  bp_pkg::word_t   pc_exe,
    input  bp_pkg::word_t   pc_target,
    input  bp_pkg::word_t   bimm_exe,
    input  bp_pkg::word_t   pc_fetch,
    output logic            prediction,
    output bp_pkg::word_t   target
);

    import bp_pkg::*;

    tbl_if #(.payload_t(br_payload_t), .DEPTH(BTB_DEPTH)) br_if ();
    tbl_if #(.payload_t(jp_payload_t), .DEPTH(JTB_DEPTH)) jp_if ();

    tag_table #(
        .DEPTH     (BTB_DEPTH),
        .payload_t (br_payload_t)
    ) u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_exe   (pc_exe),
        .pc_fetch (pc_fetch),
        .bus      (br_if.tbl)
    );

    tag_table #(
        .DEPTH     (JTB_DEPTH),
        .payload_t (jp_payload_t)
    ) u_jtb (
        .clk      (clk),
        .rst      (rst),
        .pc_exe   (pc_exe),
        .pc_fetch (pc_fetch),
        .bus      (jp_if.tbl)
    );

    bp_update_ctrl u_ctrl (
        .sel          (sel),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .pc_target    (pc_target),
        .bimm_exe     (bimm_exe),
        .br           (br_if.ctrl),
        .jp           (jp_if.ctrl)
    );

    bp_fetch_lookup u_lookup (
        .pc_fetch   (pc_fetch),
        .br         (br_if.lookup),
        .jp         (jp_if.lookup),
        .prediction (prediction),
        .target     (target)
    );

endmodule

`default_nettype wire

/* rtl/bp_fetch_lookup.sv */
`default_nettype none

module bp_fetch_lookup (
    input  bp_pkg::word_t pc_fetch,
    tbl_if.lookup         br,
    tbl_if.lookup         jp,
    output logic          prediction,
    output bp_pkg::word_t target
);

    import bp_pkg::*;

    logic  br_taken;
    word_t br_dest;

    hist_predictor u_fetch_pred (
        .hist      (br.fetch_payload.hist),
        .pred_hist (br.fetch_payload.pred_hist),
        .taken     (br_taken)
    );

    // sign-extended bimm, bit 0 is always zero
    assign br_dest = pc_fetch + {{19{br.fetch_payload.offset[11]}}, br.fetch_payload.offset, 1'b0};

    always_comb begin
        prediction = 1'b0;
        target     = '1; // all ones marks no target
        if (br.fetch_hit) begin
            prediction = br_taken; // branch table wins over jump table
            if (br_taken) begin
                target = br_dest;
            end
        end else if (jp.fetch_hit) begin
            prediction = 1'b1;
            target     = jp.fetch_payload.target;
        end
    end

endmodule

`default_nettype wire

/* rtl/bp_update_ctrl.sv */
`default_nettype none

module bp_update_ctrl (
    input  logic            sel,
    input  bp_pkg::opcode_t opcode,
    input  logic            branch_taken,
    input  bp_pkg::word_t   pc_target,
    input  bp_pkg::word_t   bimm_exe,
    tbl_if.ctrl             br,
    tbl_if.ctrl             jp
);

    import bp_pkg::*;

    localparam hist_t HIST_INIT = 10'h200; // one taken outcome

    logic        exe_pred; // what the resident entry predicts right now
    br_payload_t br_pay;
    jp_payload_t jp_pay;

    hist_predictor u_exe_pred (
        .hist      (br.exe_payload.hist),
        .pred_hist (br.exe_payload.pred_hist),
        .taken     (exe_pred)
    );

    always_comb begin
        br.alloc     = 1'b0;
        br.upd       = 1'b0;
        br.upd_index = br.exe_index;
        br_pay       = br.exe_payload;
        if (sel && opcode == op_br) begin
            if (br.exe_hit) begin
                br.upd           = 1'b1;
                br_pay.hist      = {branch_taken, br.exe_payload.hist[HIST_W-1:1]};
                br_pay.pred_hist = {exe_pred, br.exe_payload.pred_hist[HIST_W-1:1]};
            end else if (branch_taken) begin
                br.alloc         = 1'b1; // only taken branches earn an entry
                br_pay.offset    = bimm_exe[12:1];
                br_pay.hist      = HIST_INIT;
                br_pay.pred_hist = '0;
            end
        end
        br.wr_payload = br_pay;
    end

    always_comb begin
        jp.alloc      = 1'b0;
        jp.upd        = 1'b0; // a jal target is fixed per pc
        jp.upd_index  = jp.exe_index;
        jp_pay.target = pc_target;
        if (sel && opcode == op_jal && branch_taken && !jp.exe_hit) begin
            jp.alloc = 1'b1;
        end
        jp.wr_payload = jp_pay;
    end

endmodule

`default_nettype wire

/* rtl/tag_table.sv */
`default_nettype none

module tag_table #(
    parameter int  DEPTH     = 16,
    parameter type payload_t = logic
) (
    input  logic          clk,
    input  logic          rst,
    input  bp_pkg::word_t pc_exe,
    input  bp_pkg::word_t pc_fetch,
    tbl_if.tbl            bus
);

    import bp_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0] valid;
    word_t            pc_q  [DEPTH];
    payload_t         pay_q [DEPTH];

    logic [DEPTH-1:0] exe_match;
    logic [DEPTH-1:0] fetch_match;
    logic [IDX_W-1:0] fetch_index;
    logic [IDX_W-1:0] head;        // oldest entry, next to be replaced

    // or-reduce encoder, relies on at most one match per pc
    function automatic logic [IDX_W-1:0] encode(input logic [DEPTH-1:0] onehot);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (onehot[i]) begin
                idx = idx | IDX_W'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            exe_match[i]   = valid[i] && (pc_q[i] == pc_exe);
            fetch_match[i] = valid[i] && (pc_q[i] == pc_fetch);
        end
    end

    assign bus.exe_hit       = |exe_match;
    assign bus.exe_index     = encode(exe_match);
    assign bus.exe_payload   = pay_q[bus.exe_index];
    assign bus.fetch_hit     = |fetch_match;
    assign fetch_index       = encode(fetch_match);
    assign bus.fetch_payload = pay_q[fetch_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            head  <= '0;
        end else if (bus.alloc) begin
            valid[head] <= 1'b1;
            head        <= head + 1'b1; // wraps at DEPTH
        end
    end

    always_ff @(posedge clk) begin
        if (bus.alloc) begin
            pc_q[head]  <= pc_exe;
            pay_q[head] <= bus.wr_payload;
        end else if (bus.upd) begin
            pay_q[bus.upd_index] <= bus.wr_payload; // pc stays, payload only
        end
    end

endmodule

`default_nettype wire

/* rtl/hist_predictor.sv */
`default_nettype none

module hist_predictor (
    input  bp_pkg::hist_t hist,
    input  bp_pkg::hist_t pred_hist,
    output logic          taken
);

    import bp_pkg::*;

    hist_t mix; // disagreement between outcomes and guesses

    assign mix = hist ^ pred_hist;

    always_comb begin
        if (hist >= TAKE_MIN) begin
            taken = 1'b1;
        end else if (hist < KEEP_MIN) begin
            taken = 1'b0;
        end else if (mix >= FLIP_MIN) begin
            taken = ~pred_hist[HIST_W-1]; // recent guesses were poor, flip
        end else begin
            taken = pred_hist[HIST_W-1];  // follow the last guess
        end
    end

endmodule

`default_nettype wire

/* rtl/tbl_if.sv */
`default_nettype none

interface tbl_if #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
);

    localparam int IDX_W = $clog2(DEPTH);

    logic             exe_hit;       // pc_exe found in a valid entry
    logic [IDX_W-1:0] exe_index;
    payload_t         exe_payload;
    logic             fetch_hit;     // pc_fetch found in a valid entry
    payload_t         fetch_payload;
    logic             alloc;         // write new entry at head
    logic             upd;           // rewrite payload at upd_index
    logic [IDX_W-1:0] upd_index;
    payload_t         wr_payload;

    modport tbl (
        output exe_hit, exe_index, exe_payload, fetch_hit, fetch_payload,
        input  alloc, upd, upd_index, wr_payload
    );

    modport ctrl (
        input  exe_hit, exe_index, exe_payload,
        output alloc, upd, upd_index, wr_payload
    );

    modport lookup (
        input fetch_hit, fetch_payload
    );

endinterface

`default_nettype wire

/* rtl/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    typedef logic [31:0] word_t;

    // rv32i major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_fence = 7'b0001111,
        op_csr   = 7'b1110011
    } opcode_t;

    localparam int HIST_W = 10;

    typedef logic [HIST_W-1:0] hist_t; // msb is the newest event

    // prediction bands over the outcome history
    localparam hist_t TAKE_MIN = 10'h380; // at or above, always taken
    localparam hist_t KEEP_MIN = 10'h010; // below, never taken
    localparam hist_t FLIP_MIN = 10'h350; // xor distance that inverts the last guess

    typedef struct packed {
        logic [11:0] offset;    // bimm[12:1]
        hist_t       hist;      // taken / not taken outcomes
        hist_t       pred_hist; // what the entry predicted
    } br_payload_t;

    typedef struct packed {
        word_t target;
    } jp_payload_t;

endpackage

`default_nettype wire
